// ==== rtl/tcb_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB interconnect package: bus widths, interface count, priority table,
// response delay, memory depth and the transfer operation type
////////////////////////////////////////////////////////////////////////////

package tcb_pkg;

////////////////////////////////////////////////////////////////////////////
// interconnect size
////////////////////////////////////////////////////////////////////////////

  // number of manager interfaces
  localparam int unsigned TCB_IFN = 2;
  // manager index width
  localparam int unsigned TCB_IFL = $clog2(TCB_IFN);

  // priority per interface, lower value wins
  // interface 0 -> priority 0, interface 1 -> priority 1
  localparam bit [TCB_IFL-1:0] TCB_PRI [TCB_IFN] = '{1'd0, 1'd1};

////////////////////////////////////////////////////////////////////////////
// bus format
////////////////////////////////////////////////////////////////////////////

  // word address width
  localparam int unsigned TCB_AW = 8;
  // data width
  localparam int unsigned TCB_DW = 32;
  // byte enables, one per data byte
  localparam int unsigned TCB_BW = TCB_DW / 8;

  // cycles from read transfer to read data
  localparam int unsigned TCB_DLY = 1;

  // memory words, covers the full address range
  localparam int unsigned TCB_MEM_DEPTH = 256;

  // transfer operation
  typedef enum logic {
    TCB_READ  = 1'b0,
    TCB_WRITE = 1'b1
  } tcb_op_e;

endpackage: tcb_pkg

// ==== rtl/tcb_lib_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// fixed priority arbiter for TCB managers
////////////////////////////////////////////////////////////////////////////

module tcb_lib_arbiter (
  // request valids, one per manager
  input  logic                        tcb_vld [tcb_pkg::TCB_IFN],
  // index of the winning manager
  output logic [tcb_pkg::TCB_IFL-1:0] sel
);

////////////////////////////////////////////////////////////////////////////
// reorder valids by priority
////////////////////////////////////////////////////////////////////////////

  // valids indexed by priority level instead of interface
  logic                        pri_vld [tcb_pkg::TCB_IFN];
  // interface that owns each priority level
  logic [tcb_pkg::TCB_IFL-1:0] pri_idx [tcb_pkg::TCB_IFN];

  always_comb begin
    for (int p = 0; p < tcb_pkg::TCB_IFN; p++) begin
      // unused levels stay idle
      pri_vld[p] = 1'b0;
      pri_idx[p] = '0;
      for (int i = 0; i < tcb_pkg::TCB_IFN; i++) begin
        if (int'(tcb_pkg::TCB_PRI[i]) == p) begin
          pri_vld[p] = tcb_vld[i];
          pri_idx[p] = i[tcb_pkg::TCB_IFL-1:0];
        end
      end
    end
  end

////////////////////////////////////////////////////////////////////////////
// priority encoder
////////////////////////////////////////////////////////////////////////////

  // walk from lowest priority up, so the highest active level wins
  // don't care when nothing is valid, the mux gates on sub_vld
  always_comb begin
    sel = 'x;
    for (int p = tcb_pkg::TCB_IFN - 1; p >= 0; p--) begin
      if (pri_vld[p]) begin
        sel = pri_idx[p];
      end
    end
  end

endmodule: tcb_lib_arbiter

// ==== rtl/tcb_lib_multiplexer.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB multiplexer: many managers onto one subordinate, with read data
// steered back through an ownership pipeline
////////////////////////////////////////////////////////////////////////////

module tcb_lib_multiplexer (
  input  logic                        clk,
  input  logic                        rst_n,
  // manager select from the arbiter
  input  logic [tcb_pkg::TCB_IFL-1:0] sel,
  // manager side requests
  input  logic                        tcb_vld [tcb_pkg::TCB_IFN],
  input  tcb_pkg::tcb_op_e            tcb_op  [tcb_pkg::TCB_IFN],
  input  logic [tcb_pkg::TCB_AW-1:0]  tcb_adr [tcb_pkg::TCB_IFN],
  input  logic [tcb_pkg::TCB_BW-1:0]  tcb_ben [tcb_pkg::TCB_IFN],
  input  logic [tcb_pkg::TCB_DW-1:0]  tcb_wdt [tcb_pkg::TCB_IFN],
  // manager side handshake and response
  output logic                        tcb_rdy [tcb_pkg::TCB_IFN],
  output logic [tcb_pkg::TCB_DW-1:0]  tcb_rdt [tcb_pkg::TCB_IFN],
  // subordinate side request
  output logic                        sub_vld,
  output tcb_pkg::tcb_op_e            sub_op,
  output logic [tcb_pkg::TCB_AW-1:0]  sub_adr,
  output logic [tcb_pkg::TCB_BW-1:0]  sub_ben,
  output logic [tcb_pkg::TCB_DW-1:0]  sub_wdt,
  // subordinate side handshake and response
  input  logic                        sub_rdy,
  input  logic [tcb_pkg::TCB_DW-1:0]  sub_rdt
);

////////////////////////////////////////////////////////////////////////////
// request path
////////////////////////////////////////////////////////////////////////////

  // any manager requesting
  always_comb begin
    sub_vld = 1'b0;
    for (int i = 0; i < tcb_pkg::TCB_IFN; i++) begin
      sub_vld = sub_vld | tcb_vld[i];
    end
  end

  // request fields from the granted manager
  assign sub_op  = tcb_op [sel];
  assign sub_adr = tcb_adr[sel];
  assign sub_ben = tcb_ben[sel];
  assign sub_wdt = tcb_wdt[sel];

  // ready only to the winner, and only while it requests
  always_comb begin
    for (int i = 0; i < tcb_pkg::TCB_IFN; i++) begin
      tcb_rdy[i] = sub_rdy & tcb_vld[i] & (int'(sel) == i);
    end
  end

////////////////////////////////////////////////////////////////////////////
// ownership pipeline
////////////////////////////////////////////////////////////////////////////

  // read transfer on the subordinate port this cycle
  logic                        rd_xfr;
  // one entry per cycle of response delay
  logic                        own_vld [tcb_pkg::TCB_DLY];
  logic [tcb_pkg::TCB_IFL-1:0] own_sel [tcb_pkg::TCB_DLY];

  assign rd_xfr = sub_vld & sub_rdy & (sub_op == tcb_pkg::TCB_READ);

  // valid bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int d = 0; d < tcb_pkg::TCB_DLY; d++) begin
        own_vld[d] <= 1'b0;
      end
    end else begin
      own_vld[0] <= rd_xfr;
      for (int d = 1; d < tcb_pkg::TCB_DLY; d++) begin
        own_vld[d] <= own_vld[d-1];
      end
    end
  end

  // owner index, qualified by own_vld
  always_ff @(posedge clk) begin
    own_sel[0] <= sel;
    for (int d = 1; d < tcb_pkg::TCB_DLY; d++) begin
      own_sel[d] <= own_sel[d-1];
    end
  end

////////////////////////////////////////////////////////////////////////////
// response path
////////////////////////////////////////////////////////////////////////////

  // read data to the owner at pipeline end, zero elsewhere
  always_comb begin
    for (int i = 0; i < tcb_pkg::TCB_IFN; i++) begin
      if (own_vld[tcb_pkg::TCB_DLY-1] && (int'(own_sel[tcb_pkg::TCB_DLY-1]) == i)) begin
        tcb_rdt[i] = sub_rdt;
      end else begin
        tcb_rdt[i] = '0;
      end
    end
  end

endmodule: tcb_lib_multiplexer

// ==== rtl/tcb_mem_sub.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB memory subordinate with byte enables and fixed read delay
////////////////////////////////////////////////////////////////////////////

module tcb_mem_sub (
  input  logic                       clk,
  input  logic                       rst_n,
  // request
  input  logic                       sub_vld,
  input  tcb_pkg::tcb_op_e           sub_op,
  input  logic [tcb_pkg::TCB_AW-1:0] sub_adr,
  input  logic [tcb_pkg::TCB_BW-1:0] sub_ben,
  input  logic [tcb_pkg::TCB_DW-1:0] sub_wdt,
  // handshake and response
  output logic                       sub_rdy,
  output logic [tcb_pkg::TCB_DW-1:0] sub_rdt
);

  // word storage
  logic [tcb_pkg::TCB_DW-1:0] mem [tcb_pkg::TCB_MEM_DEPTH];

  // read delay line
  logic [tcb_pkg::TCB_DW-1:0] rd_dat [tcb_pkg::TCB_DLY];

  // transfer qualifiers
  logic                       wr_en;
  logic                       rd_en;

  // never stalls
  assign sub_rdy = 1'b1;

  assign wr_en = sub_vld & sub_rdy & (sub_op == tcb_pkg::TCB_WRITE);
  assign rd_en = sub_vld & sub_rdy & (sub_op == tcb_pkg::TCB_READ);

  // contents start cleared
  initial begin
    for (int w = 0; w < tcb_pkg::TCB_MEM_DEPTH; w++) begin
      mem[w] = '0;
    end
  end

////////////////////////////////////////////////////////////////////////////
// write port
////////////////////////////////////////////////////////////////////////////

  // only enabled bytes are updated
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < tcb_pkg::TCB_BW; b++) begin
        if (sub_ben[b]) begin
          mem[sub_adr][8*b+:8] <= sub_wdt[8*b+:8];
        end
      end
    end
  end

////////////////////////////////////////////////////////////////////////////
// read port
////////////////////////////////////////////////////////////////////////////

  // first stage samples the array, later stages add delay
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int d = 0; d < tcb_pkg::TCB_DLY; d++) begin
        rd_dat[d] <= '0;
      end
    end else begin
      rd_dat[0] <= rd_en ? mem[sub_adr] : '0;
      for (int d = 1; d < tcb_pkg::TCB_DLY; d++) begin
        rd_dat[d] <= rd_dat[d-1];
      end
    end
  end

  assign sub_rdt = rd_dat[tcb_pkg::TCB_DLY-1];

endmodule: tcb_mem_sub

// ==== rtl/tcb_ic_top.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB interconnect top: arbiter, multiplexer and memory subordinate
////////////////////////////////////////////////////////////////////////////

module tcb_ic_top (
  input  logic                       clk,
  input  logic                       rst_n,
  // manager requests
  input  logic                       tcb_vld [tcb_pkg::TCB_IFN],
  input  tcb_pkg::tcb_op_e           tcb_op  [tcb_pkg::TCB_IFN],
  input  logic [tcb_pkg::TCB_AW-1:0] tcb_adr [tcb_pkg::TCB_IFN],
  input  logic [tcb_pkg::TCB_BW-1:0] tcb_ben [tcb_pkg::TCB_IFN],
  input  logic [tcb_pkg::TCB_DW-1:0] tcb_wdt [tcb_pkg::TCB_IFN],
  // manager handshake and read data
  output logic                       tcb_rdy [tcb_pkg::TCB_IFN],
  output logic [tcb_pkg::TCB_DW-1:0] tcb_rdt [tcb_pkg::TCB_IFN]
);

////////////////////////////////////////////////////////////////////////////
// internal wires
////////////////////////////////////////////////////////////////////////////

  // winning manager
  logic [tcb_pkg::TCB_IFL-1:0] sel;

  // shared subordinate port
  logic                       sub_vld;
  tcb_pkg::tcb_op_e           sub_op;
  logic [tcb_pkg::TCB_AW-1:0] sub_adr;
  logic [tcb_pkg::TCB_BW-1:0] sub_ben;
  logic [tcb_pkg::TCB_DW-1:0] sub_wdt;
  logic                       sub_rdy;
  logic [tcb_pkg::TCB_DW-1:0] sub_rdt;

////////////////////////////////////////////////////////////////////////////
// instances
////////////////////////////////////////////////////////////////////////////

  // picks one requester per cycle
  tcb_lib_arbiter i_arbiter (
    .tcb_vld (tcb_vld),
    .sel     (sel)
  );

  // request mux and read data return
  tcb_lib_multiplexer i_multiplexer (
    .clk     (clk),
    .rst_n   (rst_n),
    .sel     (sel),
    .tcb_vld (tcb_vld),
    .tcb_op  (tcb_op),
    .tcb_adr (tcb_adr),
    .tcb_ben (tcb_ben),
    .tcb_wdt (tcb_wdt),
    .tcb_rdy (tcb_rdy),
    .tcb_rdt (tcb_rdt),
    .sub_vld (sub_vld),
    .sub_op  (sub_op),
    .sub_adr (sub_adr),
    .sub_ben (sub_ben),
    .sub_wdt (sub_wdt),
    .sub_rdy (sub_rdy),
    .sub_rdt (sub_rdt)
  );

  // shared memory
  tcb_mem_sub i_mem_sub (
    .clk     (clk),
    .rst_n   (rst_n),
    .sub_vld (sub_vld),
    .sub_op  (sub_op),
    .sub_adr (sub_adr),
    .sub_ben (sub_ben),
    .sub_wdt (sub_wdt),
    .sub_rdy (sub_rdy),
    .sub_rdt (sub_rdt)
  );

endmodule: tcb_ic_top

// ==== tb/tcb_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the TCB interconnect: random two-manager traffic checked
// against a reference memory, priority rule and read response timing
////////////////////////////////////////////////////////////////////////////

module tcb_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // transfers per manager
  localparam int N_XFR    = 400;
  // cycles with rst_n low
  localparam int RST_CYC  = 8;
  // quiet cycles after reset, no requests
  localparam int IDLE_CYC = 4;
  // run limit in clock cycles
  localparam int MAX_CYC  = 2 * N_XFR * int'(tcb_pkg::TCB_IFN) + RST_CYC;

  localparam int IFN = int'(tcb_pkg::TCB_IFN);

  logic                       clk;
  logic                       rst_n;

  // manager ports of the DUT
  logic                       tcb_vld [tcb_pkg::TCB_IFN];
  tcb_pkg::tcb_op_e           tcb_op  [tcb_pkg::TCB_IFN];
  logic [tcb_pkg::TCB_AW-1:0] tcb_adr [tcb_pkg::TCB_IFN];
  logic [tcb_pkg::TCB_BW-1:0] tcb_ben [tcb_pkg::TCB_IFN];
  logic [tcb_pkg::TCB_DW-1:0] tcb_wdt [tcb_pkg::TCB_IFN];
  logic                       tcb_rdy [tcb_pkg::TCB_IFN];
  logic [tcb_pkg::TCB_DW-1:0] tcb_rdt [tcb_pkg::TCB_IFN];

////////////////////////////////////////////////////////////////////////////
// reference model state
////////////////////////////////////////////////////////////////////////////

  // memory image, starts cleared like the DUT
  logic [tcb_pkg::TCB_DW-1:0] ref_mem [tcb_pkg::TCB_MEM_DEPTH];

  // reads in flight: data, owner, cycle it is due
  logic [tcb_pkg::TCB_DW-1:0] exp_dat_q [$];
  int                         exp_own_q [$];
  int                         exp_due_q [$];

  // per manager bookkeeping
  bit                         pend      [tcb_pkg::TCB_IFN];
  bit                         xfr_done  [tcb_pkg::TCB_IFN];
  int                         issued    [tcb_pkg::TCB_IFN];
  int                         completed [tcb_pkg::TCB_IFN];

  // rising edges seen so far
  int                         cyc;
  int                         seed;

  tcb_ic_top i_tcb_ic_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .tcb_vld (tcb_vld),
    .tcb_op  (tcb_op),
    .tcb_adr (tcb_adr),
    .tcb_ben (tcb_ben),
    .tcb_wdt (tcb_wdt),
    .tcb_rdy (tcb_rdy),
    .tcb_rdt (tcb_rdt)
  );

////////////////////////////////////////////////////////////////////////////
// clock and cycle limit
////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // counts edges, stops a stuck run
  initial begin
    cyc = 0;
    forever begin
      @(posedge clk);
      cyc = cyc + 1;
      if (cyc > MAX_CYC) begin
        $display("ERROR: run did not complete within %0d clock cycles", MAX_CYC);
        $display("Some tests failed");
        $fatal(1, "timeout");
      end
    end
  end

////////////////////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0d ns: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  // all requests issued, answered and drained
  function automatic bit all_done();
    bit ok;
    ok = (exp_due_q.size() == 0);
    for (int i = 0; i < IFN; i++) begin
      if (pend[i] || issued[i] < N_XFR) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // runs 1 ns after a rising edge
  task automatic drive_requests();
    logic [31:0] rnd;
    for (int i = 0; i < IFN; i++) begin
      // transfer at the last edge ends the request
      if (pend[i] && xfr_done[i]) begin
        pend[i]    = 1'b0;
        tcb_vld[i] = 1'b0;
      end
      xfr_done[i] = 1'b0;
      rnd = $random(seed);
      // new request three times in four when free
      if (!pend[i] && issued[i] < N_XFR && rnd[1:0] != 2'b00) begin
        pend[i]    = 1'b1;
        issued[i]  = issued[i] + 1;
        tcb_vld[i] = 1'b1;
        tcb_op[i]  = rnd[2] ? tcb_pkg::TCB_WRITE : tcb_pkg::TCB_READ;
        // 16 words only, so managers hit the same words
        tcb_adr[i]      = '0;
        tcb_adr[i][3:0] = rnd[6:3];
        tcb_ben[i]      = rnd[7 +: tcb_pkg::TCB_BW];
        rnd = $random(seed);
        tcb_wdt[i] = rnd;
      end
    end
  endtask

  // runs at the falling edge, where all DUT outputs are settled
  task automatic check_cycle();
    logic exp_rdy;
    bit   due_now;
    // read response side
    due_now = (exp_due_q.size() > 0) && (exp_due_q[0] == cyc);
    for (int i = 0; i < IFN; i++) begin
      if (due_now && exp_own_q[0] == i) begin
        assert (tcb_rdt[i] === exp_dat_q[0]) else begin
          report_mismatch($sformatf("manager %0d rdt %h, expected %h",
                                    i, tcb_rdt[i], exp_dat_q[0]));
        end
      end else begin
        // no response routed to this manager
        assert (tcb_rdt[i] === '0) else begin
          report_mismatch($sformatf("manager %0d rdt %h, expected zero",
                                    i, tcb_rdt[i]));
        end
      end
    end
    if (due_now) begin
      void'(exp_dat_q.pop_front());
      void'(exp_own_q.pop_front());
      void'(exp_due_q.pop_front());
    end
    // handshake side
    for (int i = 0; i < IFN; i++) begin
      // ready only if no requester with a smaller priority value
      exp_rdy = tcb_vld[i];
      for (int j = 0; j < IFN; j++) begin
        if (j != i && tcb_vld[j] && tcb_pkg::TCB_PRI[j] < tcb_pkg::TCB_PRI[i]) begin
          exp_rdy = 1'b0;
        end
      end
      assert (tcb_rdy[i] === exp_rdy) else begin
        report_mismatch($sformatf("manager %0d rdy %b, expected %b",
                                  i, tcb_rdy[i], exp_rdy));
      end
      // transfer at the coming edge
      if (tcb_vld[i] && tcb_rdy[i]) begin
        completed[i] = completed[i] + 1;
        xfr_done[i]  = 1'b1;
        if (tcb_op[i] == tcb_pkg::TCB_READ) begin
          exp_dat_q.push_back(ref_mem[tcb_adr[i]]);
          exp_own_q.push_back(i);
          exp_due_q.push_back(cyc + int'(tcb_pkg::TCB_DLY));
        end else begin
          for (int b = 0; b < int'(tcb_pkg::TCB_BW); b++) begin
            if (tcb_ben[i][b]) begin
              ref_mem[tcb_adr[i]][8*b +: 8] = tcb_wdt[i][8*b +: 8];
            end
          end
        end
      end
    end
  endtask

////////////////////////////////////////////////////////////////////////////
// main sequence
////////////////////////////////////////////////////////////////////////////

  initial begin
    seed  = 41657;
    rst_n = 1'b0;
    for (int i = 0; i < IFN; i++) begin
      tcb_vld[i]   = 1'b0;
      tcb_op[i]    = tcb_pkg::TCB_READ;
      tcb_adr[i]   = '0;
      tcb_ben[i]   = '0;
      tcb_wdt[i]   = '0;
      pend[i]      = 1'b0;
      xfr_done[i]  = 1'b0;
      issued[i]    = 0;
      completed[i] = 0;
    end
    for (int w = 0; w < int'(tcb_pkg::TCB_MEM_DEPTH); w++) begin
      ref_mem[w] = '0;
    end

    // reset
    repeat (RST_CYC) @(posedge clk);
    #1 rst_n = 1'b1;

    // idle bus: rdy low, rdt zero
    repeat (IDLE_CYC) begin
      @(negedge clk);
      check_cycle();
    end

    // random traffic
    while (!all_done()) begin
      @(posedge clk);
      #1;
      drive_requests();
      @(negedge clk);
      check_cycle();
    end

    // every issued request completed exactly once
    for (int i = 0; i < IFN; i++) begin
      assert (completed[i] == issued[i] && issued[i] == N_XFR) else begin
        report_mismatch($sformatf("manager %0d issued %0d, completed %0d",
                                  i, issued[i], completed[i]));
      end
    end

    $display("All tests passed");
    $finish;
  end

endmodule: tcb_tb

// ==== compile.f ====
rtl/tcb_pkg.sv
rtl/tcb_lib_arbiter.sv
rtl/tcb_lib_multiplexer.sv
rtl/tcb_mem_sub.sv
rtl/tcb_ic_top.sv
tb/tcb_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the TCB interconnect testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module tcb_tb -o tcb_tb_sim

# a failing run exits nonzero, the log decides the result
./obj_dir/tcb_tb_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  echo "simulation FAILED, see $LOG"
  exit 1
fi

echo "simulation passed"
exit 0
